// File: src/vcap_defines.svh
`ifndef VCAP_DEFINES_SVH
`define VCAP_DEFINES_SVH

`define LINE_WIDTH   640
`define BUFFER_LINES 4
`define SLOT_BITS    2    // ring index of a line slot
`define COL_BITS     10
`define ADDR_WIDTH   12   // slot bits on top of column bits
`define CREDIT_BITS  3    // holds 0 to BUFFER_LINES

`define H_START_480P 44
`define H_END_480P   684
`define H_START_240P 1
`define H_END_240P   641

`define V_END_480P   480
`define V_END_240P   240

`define H_TRIGGER    320  // on source line 0

`endif

// File: src/video_pkg.sv
package video_pkg;

    // one source pixel
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    typedef enum logic {
        mode_480p = 1'b0,
        mode_240p = 1'b1   // lines are emitted twice
    } capture_mode_e;

    // free running source position
    typedef struct packed {
        logic [11:0] counter_x;
        logic [11:0] counter_y;
    } src_timing_t;

endpackage

// File: src/linebuf_pkg.sv
`include "vcap_defines.svh"

package linebuf_pkg;

    import video_pkg::*;

    typedef struct packed {
        logic                   en;
        logic [`ADDR_WIDTH-1:0] addr;   // {slot, column}
        rgb_t                   data;
    } buf_write_t;

    typedef struct packed {
        logic valid;
        logic first;   // column 0 of a line repeat
        logic last;    // final column of a line repeat
        rgb_t data;
    } out_pixel_t;

    typedef enum logic [1:0] {
        rd_idle,
        rd_line,
        rd_drain
    } reader_state_e;

endpackage

// File: src/video_capture.sv
`timescale 1ns/1ns
`include "vcap_defines.svh"

module video_capture
    import video_pkg::*;
    import linebuf_pkg::*;
(
    input  logic          clock,
    input  logic          arst_n,
    input  rgb_t          pixel,
    input  src_timing_t   timing,
    input  capture_mode_e mode,
    input  logic          credit_return,
    output buf_write_t    wr,
    output logic          line_commit,
    output logic          start_trigger,
    output logic          overrun
);

    logic [11:0]             h_start;
    logic [11:0]             h_end;
    logic [11:0]             v_end;
    logic                    in_window;
    logic                    first_col;
    logic                    last_col;
    logic                    has_credit;
    logic                    keep;
    logic [`CREDIT_BITS-1:0] credits;
    logic [`SLOT_BITS-1:0]   wr_slot;
    logic                    line_active;
    logic                    commit_d;
    logic                    wr_en;
    logic [`ADDR_WIDTH-1:0]  wr_addr;
    rgb_t                    wr_data;

    always_comb begin
        if (mode == mode_240p) begin
            h_start = 12'(`H_START_240P);
            h_end   = 12'(`H_END_240P);
            v_end   = 12'(`V_END_240P);
        end else begin
            h_start = 12'(`H_START_480P);
            h_end   = 12'(`H_END_480P);
            v_end   = 12'(`V_END_480P);
        end
    end

    assign in_window = (timing.counter_y < v_end) && (timing.counter_x >= h_start)
                       && (timing.counter_x < h_end);
    assign first_col  = in_window && (timing.counter_x == h_start);
    assign last_col   = in_window && (timing.counter_x == h_end - 12'd1);
    assign has_credit = (credits != '0);
    assign keep       = first_col ? has_credit : (line_active && in_window);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            credits       <= `CREDIT_BITS'(`BUFFER_LINES);
            wr_slot       <= '0;
            line_active   <= 1'b0;
            wr_en         <= 1'b0;
            commit_d      <= 1'b0;
            line_commit   <= 1'b0;
            start_trigger <= 1'b0;
            overrun       <= 1'b0;
        end else begin
            credits <= credits - `CREDIT_BITS'(first_col && has_credit)
                       + `CREDIT_BITS'(credit_return);
            wr_en       <= keep;
            commit_d    <= keep && last_col;
            line_commit <= commit_d;   // one clock after the last write
            overrun     <= first_col && !has_credit;   // whole line dropped
            start_trigger <= (timing.counter_x == 12'(`H_TRIGGER))
                             && (timing.counter_y == 12'd0);
            if (first_col) begin
                line_active <= has_credit;
            end else if (last_col) begin
                line_active <= 1'b0;
            end
            if (keep && last_col) begin
                wr_slot <= wr_slot + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        wr_addr <= {wr_slot, `COL_BITS'(timing.counter_x - h_start)};
        wr_data <= pixel;
    end

    assign wr = '{en: wr_en, addr: wr_addr, data: wr_data};

    // reader may only give back credits that were taken
    credit_bound_a: assert property (@(posedge clock) disable iff (!arst_n)
        credits <= `CREDIT_BITS'(`BUFFER_LINES));

    // the slot being written is owned, so a credit is out
    write_owns_slot_a: assert property (@(posedge clock) disable iff (!arst_n)
        wr_en |-> (credits < `CREDIT_BITS'(`BUFFER_LINES)));

endmodule

// File: src/line_buffer.sv
`timescale 1ns/1ns
`include "vcap_defines.svh"

module line_buffer
    import video_pkg::*;
    import linebuf_pkg::*;
(
    input  logic                   clock,
    input  buf_write_t             wr,
    input  logic                   rd_en,
    input  logic [`ADDR_WIDTH-1:0] rd_addr,
    output rgb_t                   rd_data
);

    rgb_t mem [`BUFFER_LINES][`LINE_WIDTH];

    logic [`SLOT_BITS-1:0] wr_slot;
    logic [`COL_BITS-1:0]  wr_col;
    logic [`SLOT_BITS-1:0] rd_slot;
    logic [`COL_BITS-1:0]  rd_col;

    assign wr_slot = wr.addr[`ADDR_WIDTH-1 -: `SLOT_BITS];
    assign wr_col  = wr.addr[`COL_BITS-1:0];
    assign rd_slot = rd_addr[`ADDR_WIDTH-1 -: `SLOT_BITS];
    assign rd_col  = rd_addr[`COL_BITS-1:0];

    always_ff @(posedge clock) begin
        if (wr.en) begin
            mem[wr_slot][wr_col] <= wr.data;
        end
    end

    // registered read port
    always_ff @(posedge clock) begin
        if (rd_en) begin
            rd_data <= mem[rd_slot][rd_col];
        end
    end

    // a slot is read only after its commit, never while it fills
    no_collision_a: assert property (@(posedge clock)
        !(wr.en && rd_en && (wr.addr == rd_addr)));

endmodule

// File: src/line_reader.sv
`timescale 1ns/1ns
`include "vcap_defines.svh"

module line_reader
    import video_pkg::*;
    import linebuf_pkg::*;
(
    input  logic                   clock,
    input  logic                   arst_n,
    input  capture_mode_e          mode,
    input  logic                   line_commit,
    output logic                   rd_en,
    output logic [`ADDR_WIDTH-1:0] rd_addr,
    input  rgb_t                   rd_data,
    output out_pixel_t             out,
    input  logic                   out_ready,
    output logic                   credit_return
);

    reader_state_e           state;
    logic [`CREDIT_BITS-1:0] pending;   // committed slots not yet released
    logic [`SLOT_BITS-1:0]   rd_slot;
    logic [`COL_BITS-1:0]    col;
    logic                    rep;
    logic                    last_col;
    logic                    last_pass;
    logic                    can_issue;
    logic                    pop;
    logic                    drain_done;
    logic                    inflight;
    logic                    inflight_first;
    logic                    inflight_last;
    logic [1:0]              count;
    out_pixel_t              q0;
    out_pixel_t              q1;
    out_pixel_t              incoming;

    assign last_col   = (col == `COL_BITS'(`LINE_WIDTH - 1));
    assign last_pass  = (mode == mode_480p) || rep;
    assign pop        = (count != 2'd0) && out_ready;
    assign can_issue  = ((count + 2'(inflight)) < 2'd2) || pop;   // skid has room
    assign rd_en      = (state == rd_line) && can_issue;
    assign rd_addr    = {rd_slot, col};
    assign drain_done = (state == rd_drain) && (count == 2'd0) && !inflight;
    assign incoming   = '{valid: 1'b1, first: inflight_first, last: inflight_last,
                          data: rd_data};

    always_comb begin
        out       = q0;
        out.valid = (count != 2'd0);
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state         <= rd_idle;
            pending       <= '0;
            rd_slot       <= '0;
            col           <= '0;
            rep           <= 1'b0;
            inflight      <= 1'b0;
            count         <= 2'd0;
            credit_return <= 1'b0;
        end else begin
            pending <= pending + `CREDIT_BITS'(line_commit) - `CREDIT_BITS'(drain_done);
            credit_return <= drain_done;
            inflight      <= rd_en;
            if (inflight && !pop) begin
                count <= count + 2'd1;
            end else if (!inflight && pop) begin
                count <= count - 2'd1;
            end
            case (state)
                rd_idle: begin
                    if (pending != '0) begin
                        state <= rd_line;
                    end
                end
                rd_line: begin
                    if (rd_en && last_col) begin
                        col <= '0;
                        rep <= !last_pass;   // second pass in 240p
                        if (last_pass) begin
                            state <= rd_drain;
                        end
                    end else if (rd_en) begin
                        col <= col + 1'b1;
                    end
                end
                rd_drain: begin
                    if (drain_done) begin
                        state   <= rd_idle;
                        rd_slot <= rd_slot + 1'b1;
                    end
                end
                default: state <= rd_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        inflight_first <= (col == '0);
        inflight_last  <= last_col;
        if (pop && (count == 2'd2)) begin
            q0 <= q1;
            if (inflight) begin
                q1 <= incoming;
            end
        end else if (inflight) begin
            if (pop || (count == 2'd0)) begin
                q0 <= incoming;
            end else begin
                q1 <= incoming;
            end
        end
    end

    out_hold_a: assert property (@(posedge clock) disable iff (!arst_n)
        (out.valid && !out_ready) |=> (out.valid && $stable(out)));

endmodule

// File: src/capture_top.sv
`timescale 1ns/1ns
`include "vcap_defines.svh"

module capture_top
    import video_pkg::*;
    import linebuf_pkg::*;
(
    input  logic          clock,
    input  logic          arst_n,
    input  rgb_t          pixel,
    input  src_timing_t   timing,
    input  capture_mode_e mode,
    input  logic          out_ready,
    output out_pixel_t    out,
    output logic          start_trigger,
    output logic          overrun
);

    buf_write_t             wr;
    logic                   line_commit;
    logic                   credit_return;
    logic                   rd_en;
    logic [`ADDR_WIDTH-1:0] rd_addr;
    rgb_t                   rd_data;

    video_capture video_capture_inst (
        .clock         (clock),
        .arst_n        (arst_n),
        .pixel         (pixel),
        .timing        (timing),
        .mode          (mode),
        .credit_return (credit_return),
        .wr            (wr),
        .line_commit   (line_commit),
        .start_trigger (start_trigger),
        .overrun       (overrun)
    );

    line_buffer line_buffer_inst (
        .clock   (clock),
        .wr      (wr),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    line_reader line_reader_inst (
        .clock         (clock),
        .arst_n        (arst_n),
        .mode          (mode),
        .line_commit   (line_commit),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .out           (out),
        .out_ready     (out_ready),
        .credit_return (credit_return)
    );

endmodule

// File: sim/capture_checker.sv
`timescale 1ns/1ns
`include "vcap_defines.svh"

module capture_checker
    import video_pkg::*;
    import linebuf_pkg::*;
(
    input  logic          clock,
    input  logic          arst_n,
    input  out_pixel_t    out,
    input  logic          out_ready,
    input  logic          start_trigger,
    input  logic          overrun,
    input  logic [127:0]  test_name,
    input  capture_mode_e mode,
    input  int            expected,   // captured lines per frame
    input  int            stall,
    input  logic          frame_begin,
    input  logic          frame_end,
    output logic          settled,
    output int            value_errors,
    output int            rule_errors
);

    int   value_count = 0;
    int   rule_count = 0;
    logic in_line = 1'b0;
    int   col = 0;
    int   line_red = 0;
    int   prev_red = -1;   // source line of the last distinct output line
    int   repeats = 0;
    int   distinct = 0;
    int   overruns = 0;
    int   triggers = 0;

    assign value_errors = value_count;
    assign rule_errors  = rule_count;
    assign settled = (distinct + overruns >= expected) && !in_line
                     && !(mode == mode_240p && repeats == 1);

    task automatic fail_value(input string what, input int exp, input int act);
        value_count++;
        $display("FAILED %s %s: expected %0d, actual %0d", string'(test_name), what, exp, act);
    endtask

    task automatic fail_rule(input string what);
        rule_count++;
        $display("test %s: %s", string'(test_name), what);
    endtask

    task automatic end_line();
        int step;
        in_line = 1'b0;
        step = (line_red - prev_red) & 255;   // red wraps past line 255
        if (mode == mode_240p && repeats == 1 && line_red == prev_red) begin
            repeats = 2;
        end else begin
            if (mode == mode_240p && repeats == 1)
                fail_value("line repeats", 2, 1);
            if (prev_red >= 0 && (step == 0 || step >= 128))
                fail_value("source line order", (prev_red + 1) & 255, line_red);
            distinct++;
            repeats  = 1;
            prev_red = line_red;
        end
    endtask

    task automatic take_pixel();
        int x;
        x = ((mode == mode_240p) ? `H_START_240P : `H_START_480P) + col;
        if (out.first) begin
            if (in_line)
                fail_rule("a line started before the previous one ended");
            if (triggers == 0)
                fail_rule("an output line came before the start trigger");
            in_line  = 1'b1;
            col      = 0;
            x        = (mode == mode_240p) ? `H_START_240P : `H_START_480P;
            line_red = int'(out.data.red);
        end
        if (!in_line) begin
            fail_rule("a pixel arrived outside an output line");
        end else begin
            if (int'(out.data.green) != (x & 255))
                fail_value("green", x & 255, int'(out.data.green));
            if (int'(out.data.blue) != ((x >> 8) & 3))
                fail_value("blue", (x >> 8) & 3, int'(out.data.blue));
            if (int'(out.data.red) != line_red)
                fail_value("red", line_red, int'(out.data.red));
            if (out.last) begin
                if (col != `LINE_WIDTH - 1)
                    fail_value("line width", `LINE_WIDTH, col + 1);
                end_line();
            end else if (col >= `LINE_WIDTH - 1) begin
                fail_rule("a line ran past its width without a last flag");
                in_line = 1'b0;   // resync on the next first flag
            end
            col++;
        end
    endtask

    task automatic check_frame();
        if (in_line)
            fail_rule("the frame ended inside an output line");
        if (mode == mode_240p && repeats == 1)
            fail_value("line repeats", 2, 1);
        if (distinct + overruns != expected)
            fail_value("captured lines", expected, distinct + overruns);
        if (triggers != 1)
            fail_value("start triggers", 1, triggers);
        if (mode == mode_480p && stall == 0 && overruns != 0)
            fail_value("overruns", 0, overruns);
        if (mode == mode_240p && stall >= 50 && overruns == 0)
            fail_rule("heavy stall in 240p mode caused no overrun");
    endtask

    always @(posedge clock) begin
        if (frame_begin) begin
            in_line  = 1'b0;
            prev_red = -1;
            repeats  = 0;
            distinct = 0;
            overruns = 0;
            triggers = 0;
        end else if (frame_end) begin
            check_frame();
        end else if (arst_n) begin
            if (overrun)
                overruns++;
            if (start_trigger) begin
                triggers++;
                if (distinct != 0 || in_line)
                    fail_rule("the start trigger came after the frame's output began");
            end
            if (out.valid && out_ready)
                take_pixel();
        end
    end

endmodule

// File: sim/tb_capture_top.sv
`timescale 1ns/1ns

module tb_capture_top
    import video_pkg::*;
    import linebuf_pkg::*;
();

    localparam int LINE_CLOCKS = 858;   // source clocks per line, blanking included

    logic          clock;
    logic          arst_n;
    rgb_t          pixel;
    src_timing_t   timing;
    capture_mode_e mode;
    logic          out_ready;
    out_pixel_t    out;
    logic          start_trigger;
    logic          overrun;
    logic [127:0]  test_name;
    int            expected;
    int            stall;
    logic          frame_begin;
    logic          frame_end;
    logic          settled;
    int            value_errors;
    int            rule_errors;
    int            tb_errors = 0;
    integer        seed = 23775;
    longint        watchdog_cycles = 0;
    logic          watchdog_armed = 1'b0;
    logic [127:0]  names [$];
    int            modes [$];
    int            lines [$];
    int            frames [$];
    int            stalls [$];
    int            expects [$];

    capture_top capture_top_inst (
        .clock         (clock),
        .arst_n        (arst_n),
        .pixel         (pixel),
        .timing        (timing),
        .mode          (mode),
        .out_ready     (out_ready),
        .out           (out),
        .start_trigger (start_trigger),
        .overrun       (overrun)
    );

    capture_checker capture_checker_inst (
        .clock         (clock),
        .arst_n        (arst_n),
        .out           (out),
        .out_ready     (out_ready),
        .start_trigger (start_trigger),
        .overrun       (overrun),
        .test_name     (test_name),
        .mode          (mode),
        .expected      (expected),
        .stall         (stall),
        .frame_begin   (frame_begin),
        .frame_end     (frame_end),
        .settled       (settled),
        .value_errors  (value_errors),
        .rule_errors   (rule_errors)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic load_tests();
        int           fd;
        int           n;
        int           m, l, fr, st, ex;
        string        text;
        logic [127:0] name;
        fd = $fopen("sim/capture_testdata.txt", "r");
        if (fd == 0) begin
            tb_errors++;
            $display("could not open sim/capture_testdata.txt");
        end else begin
            while (!$feof(fd)) begin
                text = "";
                name = '0;
                n = $fgets(text, fd);
                if (n > 0 && text.len() > 1 && text[0] != 8'h23) begin
                    n = $sscanf(text, "%s %d %d %d %d %d", name, m, l, fr, st, ex);
                    if (n == 6) begin
                        names.push_back(name);
                        modes.push_back(m);
                        lines.push_back(l);
                        frames.push_back(fr);
                        stalls.push_back(st);
                        expects.push_back(ex);
                    end else begin
                        tb_errors++;
                        $display("unreadable test data line: %s", text);
                    end
                end
            end
            $fclose(fd);
        end
        if (names.size() == 0) begin
            tb_errors++;
            $display("no tests found in the test data file");
        end
    endtask

    // one source clock, driven just after the rising edge
    task automatic drive_cycle(input int x, input int y, input int pct);
        @(posedge clock);
        #1;
        timing.counter_x = 12'(x);
        timing.counter_y = 12'(y);
        pixel.red   = 8'(y);
        pixel.green = 8'(x);
        pixel.blue  = 8'((x >> 8) & 3);
        out_ready = ($unsigned($random(seed)) % 100) >= pct;
    endtask

    task automatic drive_idle(input int pct);
        drive_cycle(0, 12'hfff, pct);   // below every window
    endtask

    task automatic apply_reset();
        drive_idle(0);
        arst_n = 1'b0;
        repeat (10) @(posedge clock);
        #1 arst_n = 1'b1;
    endtask

    task automatic drain_frame(input int limit, input int pct);
        int n;
        n = 0;
        while (!settled && n < limit) begin
            drive_idle(pct);
            n++;
        end
        repeat (64) drive_idle(pct);   // stray lines would show up here
        if (!settled) begin
            tb_errors++;
            $display("test %s: output did not finish within %0d clocks", string'(test_name),
                     limit);
        end
    endtask

    task automatic run_test(input int t);
        test_name = names[t];
        mode      = (modes[t] == 240) ? mode_240p : mode_480p;
        expected  = expects[t];
        stall     = stalls[t];
        apply_reset();
        for (int f = 0; f < frames[t]; f++) begin
            frame_begin = 1'b1;
            drive_idle(0);
            frame_begin = 1'b0;
            for (int y = 0; y < lines[t]; y++) begin
                for (int x = 0; x < LINE_CLOCKS; x++) begin
                    drive_cycle(x, y, stall);
                end
            end
            drain_frame(2 * lines[t] * LINE_CLOCKS, stall);
            frame_end = 1'b1;
            drive_idle(0);
            frame_end = 1'b0;
        end
    endtask

    initial begin
        arst_n      = 1'b0;
        pixel       = '0;
        timing      = '{counter_x: 12'd0, counter_y: 12'hfff};
        mode        = mode_480p;
        out_ready   = 1'b1;
        test_name   = '0;
        expected    = 0;
        stall       = 0;
        frame_begin = 1'b0;
        frame_end   = 1'b0;
        load_tests();
        watchdog_cycles = 1000;
        for (int t = 0; t < names.size(); t++) begin
            // plus reset and settle cycles per test
            watchdog_cycles += longint'(frames[t]) * lines[t] * LINE_CLOCKS * 3 + 200;
        end
        watchdog_armed = 1'b1;
        for (int t = 0; t < names.size(); t++) begin
            run_test(t);
        end
        repeat (4) @(posedge clock);
        $display("value errors: %0d, rule errors: %0d, testbench errors: %0d",
                 value_errors, rule_errors, tb_errors);
        if (value_errors + rule_errors + tb_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        wait (watchdog_armed === 1'b1);
        repeat (watchdog_cycles) @(posedge clock);
        $display("watchdog expired after %0d clock periods", watchdog_cycles);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: flist.f
+incdir+src
src/video_pkg.sv
src/linebuf_pkg.sv
src/video_capture.sv
src/line_buffer.sv
src/line_reader.sv
src/capture_top.sv
sim/capture_checker.sv
sim/tb_capture_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_capture_top
FLIST     = flist.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: sim/capture_testdata.txt
# name  mode(480 or 240)  lines_per_frame  frames  stall_percent  expected_lines_per_frame
# stall_percent is the share of cycles with out_ready low
basic_480p   480  20   2  0   20
basic_240p   240  20   2  0   20
stall_480p   480  24   2  30  24
heavy_240p   240  60   2  90  60
window_480p  480  485  1  0   480
window_240p  240  250  1  10  240
